// File: source/dac_pkg.sv
package dac_pkg;

  ////////////////////
  // Device constants
  ////////////////////

  localparam int                 NUM_CHANNELS     = 8;          // DAC channels
  localparam logic [4:0]         SPI_FRAME_BITS   = 5'd24;      // Bits per register write
  localparam logic [3:0]         N_CS_HIGH_CYCLES = 4'd4;       // n_cs high time before a frame
  localparam logic signed [15:0] ABS_CAL_MAX      = 16'sd4096;  // Calibration magnitude limit
  localparam logic [15:0]        DAC_MIDSCALE     = 16'd32767;  // Offset code for zero
  localparam logic [15:0]        DAC_INVALID      = 16'hFFFF;   // Never sent to the device
  localparam logic [3:0]         SPI_OP_REG_WRITE = 4'b0001;    // Device write opcode

  ////////////////////
  // Command words
  ////////////////////

  typedef enum logic [2:0] {
    CMD_NO_OP   = 3'd0,
    CMD_SET_CAL = 3'd1,
    CMD_DAC_WR  = 3'd2,
    CMD_CANCEL  = 3'd7
  } cmd_op_e;

  typedef struct packed {
    cmd_op_e     op;    // 31:29
    logic        trig;  // Wait on triggers, not on a delay
    logic        cont;  // Another command must follow
    logic        ldac;  // Pulse ldac when the wait ends
    logic        spare;
    logic [24:0] count; // Delay cycles or trigger count, SET_CAL channel and value
  } cmd_word_t;

  typedef struct packed {
    logic [15:0] odd;   // Channel 2p+1
    logic [15:0] even;  // Channel 2p
  } dac_pair_t;

  ////////////////////
  // Pipeline payloads
  ////////////////////

  typedef struct packed {
    logic        valid;
    logic [1:0]  idx;   // Pair index p
    dac_pair_t   pair;
  } pair_req_t;

  typedef struct packed {
    logic               valid;
    logic [2:0]         ch;
    logic signed [15:0] value;
  } cal_wr_t;

  typedef struct packed {
    logic [3:0]  opcode;
    logic        rsvd;
    logic [2:0]  ch;
    logic [15:0] code;
  } spi_frame_t;

  typedef struct packed {
    logic       valid;
    spi_frame_t first;  // Even channel, sent first
    spi_frame_t second;
  } frame_pair_t;

  typedef struct packed {
    logic bad_cmd;
    logic cmd_buf_underflow;
    logic cal_oob;
    logic dac_val_oob;
    logic delay_too_short;
  } dac_err_t;

  typedef enum logic [2:0] {S_IDLE, S_DELAY, S_TRIG_WAIT, S_DAC_WR, S_ERROR} seq_state_e;

endpackage

// File: source/dac_cmd_sequencer.sv
module dac_cmd_sequencer
  import dac_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  cmd_word_t cmd_buf_word,
  input  logic      cmd_buf_empty,
  input  logic      trigger,
  input  logic      tx_busy,
  input  logic      pair_done,
  input  logic      cal_oob,
  input  logic      dac_val_oob,
  output logic      cmd_buf_rd_en,
  output pair_req_t pair_req,
  output cal_wr_t   cal_wr,
  output logic      waiting_for_trig,
  output logic      ldac,
  output dac_err_t  seq_err
);

  seq_state_e  state;
  seq_state_e  nxt_state;    // State entered by the word at the buffer head
  logic        op_known;
  logic        wait_cmd;     // Head word carries a wait
  logic [24:0] delay_tmr;
  logic [24:0] trig_cnt;
  logic        do_ldac;
  logic        do_trig;
  logic        expect_next;
  logic        pair_rd;      // Pair word due this cycle
  logic [2:0]  pair_cnt;     // Pair words popped in this DAC_WR
  logic        pairs_sent;
  logic        wr_done;
  logic        delay_done;
  logic        trig_done;
  logic        in_wait;
  logic        finish;       // Current command ends this cycle
  logic        fetch;
  logic        cancel_wait;
  logic        cmd_pop;
  logic        pair_pop;
  logic        last_pair;
  logic        err_bad;
  logic        err_uf;
  logic        err_dts;
  logic        err_now;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    op_known = 1'b1;
    wait_cmd = 1'b0;
    case (cmd_buf_word.op)
      CMD_NO_OP: begin
        nxt_state = cmd_buf_word.trig ? S_TRIG_WAIT : S_DELAY;
        wait_cmd  = 1'b1;
      end
      CMD_SET_CAL: nxt_state = S_IDLE;  // Table write only
      CMD_DAC_WR: begin
        nxt_state = S_DAC_WR;
        wait_cmd  = 1'b1;
      end
      CMD_CANCEL: nxt_state = S_IDLE;   // Nothing to cancel outside a wait
      default: begin
        nxt_state = S_ERROR;
        op_known  = 1'b0;
      end
    endcase
  end

  assign in_wait    = (state == S_DELAY) || (state == S_TRIG_WAIT);
  assign delay_done = (delay_tmr <= 25'd1);
  assign trig_done  = (trig_cnt == '0) || (trigger && trig_cnt == 25'd1); // Count of 0 ends at once
  assign wr_done    = pairs_sent && !tx_busy;
  assign last_pair  = (pair_cnt == 3'(NUM_CHANNELS / 2));

  always_comb begin
    case (state)
      S_DELAY:     finish = delay_done;
      S_TRIG_WAIT: finish = trig_done;
      S_DAC_WR:    finish = wr_done && (do_trig ? (trig_cnt == '0) : delay_done);
      default:     finish = 1'b0;
    endcase
  end

  // CANCEL is taken from the head as soon as it shows up in a wait
  assign cancel_wait   = in_wait && !cmd_buf_empty && (cmd_buf_word.op == CMD_CANCEL);
  assign fetch         = (state == S_IDLE) || finish;
  assign cmd_pop       = fetch && !cmd_buf_empty && !cancel_wait;
  assign pair_pop      = pair_rd && !cmd_buf_empty && (state != S_ERROR);
  assign cmd_buf_rd_en = (state != S_ERROR) && (cmd_pop || cancel_wait || pair_pop);

  ////////////////////
  // Error detection
  ////////////////////

  assign err_bad = cmd_pop && !op_known;
  assign err_uf  = (finish && expect_next && cmd_buf_empty)
                   || (pair_rd && cmd_buf_empty && state != S_ERROR); // Missing pair word
  assign err_dts = (state == S_DAC_WR) && !do_trig && delay_done && !wr_done;
  assign err_now = err_bad || err_uf || err_dts || cal_oob || dac_val_oob;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      seq_err <= '0;
    end else begin
      if (err_bad) seq_err.bad_cmd           <= 1'b1;
      if (err_uf)  seq_err.cmd_buf_underflow <= 1'b1;
      if (err_dts) seq_err.delay_too_short   <= 1'b1;
    end
  end

  ////////////////////
  // State machine
  ////////////////////

  always_ff @(posedge clk) begin
    if (!resetn)          state <= S_IDLE;
    else if (err_now)     state <= S_ERROR;   // Held until reset
    else if (cancel_wait) state <= S_IDLE;
    else if (cmd_pop)     state <= nxt_state;
    else if (finish)      state <= S_IDLE;    // Buffer empty and nothing promised
    else if (state == S_DAC_WR && wr_done) begin
      state <= do_trig ? S_TRIG_WAIT : S_DELAY; // Delay timer keeps running
    end
  end

  // Command bits latched at the pop
  always_ff @(posedge clk) begin
    if (!resetn || cancel_wait) begin
      do_ldac     <= 1'b0;
      do_trig     <= 1'b0;
      expect_next <= 1'b0;
    end else if (cmd_pop) begin
      do_ldac     <= wait_cmd && cmd_buf_word.ldac;
      do_trig     <= wait_cmd && cmd_buf_word.trig;
      expect_next <= wait_cmd && cmd_buf_word.cont;
    end
  end

  // Delay timer, runs from the pop
  always_ff @(posedge clk) begin
    if (!resetn || cancel_wait)                          delay_tmr <= '0;
    else if (cmd_pop && wait_cmd && !cmd_buf_word.trig)  delay_tmr <= cmd_buf_word.count;
    else if (delay_tmr != '0)                            delay_tmr <= delay_tmr - 25'd1;
  end

  // Trigger counter, counts only in TRIG_WAIT
  always_ff @(posedge clk) begin
    if (!resetn || cancel_wait) begin
      trig_cnt <= '0;
    end else if (cmd_pop && wait_cmd && cmd_buf_word.trig) begin
      trig_cnt <= cmd_buf_word.count;
    end else if (state == S_TRIG_WAIT && trigger && trig_cnt != '0) begin
      trig_cnt <= trig_cnt - 25'd1;
    end
  end

  ////////////////////
  // Pair requests
  ////////////////////

  always_ff @(posedge clk) begin
    if (!resetn || state == S_ERROR) begin
      pair_rd    <= 1'b0;
      pair_cnt   <= '0;
      pairs_sent <= 1'b0;
    end else begin
      // Pair 0 right after the DAC_WR word, the rest after each pair_done
      pair_rd <= (cmd_pop && cmd_buf_word.op == CMD_DAC_WR)
                 || (state == S_DAC_WR && pair_done && !last_pair);
      if (cmd_pop && cmd_buf_word.op == CMD_DAC_WR) begin
        pair_cnt   <= '0;
        pairs_sent <= 1'b0;
      end else begin
        if (pair_pop) pair_cnt <= pair_cnt + 3'd1;
        if (state == S_DAC_WR && pair_done && last_pair) pairs_sent <= 1'b1;
      end
    end
  end

  always_comb begin
    pair_req.valid = pair_pop;
    pair_req.idx   = pair_cnt[1:0];
    pair_req.pair  = dac_pair_t'(cmd_buf_word);
    cal_wr.valid   = cmd_pop && (cmd_buf_word.op == CMD_SET_CAL);
    cal_wr.ch      = cmd_buf_word.count[18:16];
    cal_wr.value   = cmd_buf_word.count[15:0];
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign waiting_for_trig = (state == S_TRIG_WAIT);

  // One cycle after the wait ends, never on a cancel
  always_ff @(posedge clk) begin
    if (!resetn) ldac <= 1'b0;
    else         ldac <= finish && do_ldac && !cancel_wait && !err_now;
  end

endmodule

// File: source/dac_cal_stage.sv
module dac_cal_stage
  import dac_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  pair_req_t   pair_req,
  input  cal_wr_t     cal_wr,
  output frame_pair_t frame_pair,
  output logic        cal_oob,
  output logic        dac_val_oob
);

  logic signed [15:0] cal_tbl [NUM_CHANNELS];  // Per channel offset
  logic signed [17:0] mid_s;                   // Midscale, also the signed range limit
  logic               cal_in_range;
  logic               pair_invalid;
  logic               s1_valid;
  logic [1:0]         s1_idx;
  logic signed [17:0] s1_sum_even;
  logic signed [17:0] s1_sum_odd;
  logic               s1_oob;
  logic               fp_valid;
  spi_frame_t         fp_first;
  spi_frame_t         fp_second;

  // 0..65534 maps to -32767..32767
  function automatic logic signed [17:0] offset_to_signed(input logic [15:0] code);
    return $signed({2'b00, code}) - $signed({2'b00, DAC_MIDSCALE});
  endfunction

  function automatic logic signed [17:0] widen_cal(input logic signed [15:0] cal);
    return $signed({{2{cal[15]}}, cal});
  endfunction

  function automatic spi_frame_t build_frame(input logic [2:0] ch,
                                             input logic signed [17:0] sum);
    logic signed [17:0] code;
    code = sum + $signed({2'b00, DAC_MIDSCALE}); // Back to offset form
    build_frame.opcode = SPI_OP_REG_WRITE;
    build_frame.rsvd   = 1'b0;
    build_frame.ch     = ch;
    build_frame.code   = code[15:0];
  endfunction

  assign mid_s        = $signed({2'b00, DAC_MIDSCALE});
  assign cal_in_range = (cal_wr.value <= ABS_CAL_MAX) && (cal_wr.value >= -ABS_CAL_MAX);
  assign pair_invalid = (pair_req.pair.even == DAC_INVALID)
                        || (pair_req.pair.odd == DAC_INVALID);
  assign s1_oob       = (s1_sum_even > mid_s) || (s1_sum_even < -mid_s)
                        || (s1_sum_odd > mid_s) || (s1_sum_odd < -mid_s);

  ////////////////////
  // Calibration table
  ////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_CHANNELS; i++) cal_tbl[i] <= '0;
    end else if (cal_wr.valid && cal_in_range) begin
      cal_tbl[cal_wr.ch] <= cal_wr.value;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn)                            cal_oob <= 1'b0;
    else if (cal_wr.valid && !cal_in_range) cal_oob <= 1'b1;  // Value dropped
  end

  // Sticky, raised by either stage
  always_ff @(posedge clk) begin
    if (!resetn)                                  dac_val_oob <= 1'b0;
    else if (pair_req.valid && pair_invalid)      dac_val_oob <= 1'b1;
    else if (s1_valid && s1_oob)                  dac_val_oob <= 1'b1;
  end

  ////////////////////
  // Stage 1
  ////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) s1_valid <= 1'b0;
    else         s1_valid <= pair_req.valid && !pair_invalid && !cal_oob && !dac_val_oob;
  end

  always_ff @(posedge clk) begin
    if (pair_req.valid) begin
      s1_idx      <= pair_req.idx;
      s1_sum_even <= offset_to_signed(pair_req.pair.even)
                     + widen_cal(cal_tbl[{pair_req.idx, 1'b0}]);
      s1_sum_odd  <= offset_to_signed(pair_req.pair.odd)
                     + widen_cal(cal_tbl[{pair_req.idx, 1'b1}]);
    end
  end

  ////////////////////
  // Stage 2
  ////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) fp_valid <= 1'b0;
    else         fp_valid <= s1_valid && !s1_oob && !dac_val_oob;
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      fp_first  <= build_frame({s1_idx, 1'b0}, s1_sum_even);
      fp_second <= build_frame({s1_idx, 1'b1}, s1_sum_odd);
    end
  end

  assign frame_pair = '{valid: fp_valid, first: fp_first, second: fp_second};

endmodule

// File: source/dac_spi_tx.sv
module dac_spi_tx
  import dac_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  frame_pair_t frame_pair,
  output logic        tx_busy,
  output logic        pair_done,
  output logic        n_cs,
  output logic        mosi
);

  logic [2*$bits(spi_frame_t)-1:0] shreg;  // Both frames, first one on top
  logic [3:0] cs_tmr;        // n_cs high cycles left
  logic [4:0] bit_cnt;       // Bits left in the current frame
  logic       second_frame;
  logic       start;
  logic       cs_expire;
  logic       last_bit;

  assign start     = frame_pair.valid && !tx_busy;  // One pair at a time
  assign cs_expire = (cs_tmr == 4'd1);
  assign last_bit  = !n_cs && (bit_cnt == 5'd1);

  ////////////////////
  // Frame sequencing
  ////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tx_busy      <= 1'b0;
      pair_done    <= 1'b0;
      n_cs         <= 1'b1;
      cs_tmr       <= '0;
      bit_cnt      <= '0;
      second_frame <= 1'b0;
    end else begin
      pair_done <= 1'b0;
      if (start) begin
        tx_busy      <= 1'b1;
        cs_tmr       <= N_CS_HIGH_CYCLES;
        second_frame <= 1'b0;
      end else if (cs_tmr != '0) begin
        cs_tmr <= cs_tmr - 4'd1;
        if (cs_expire) begin
          n_cs    <= 1'b0;            // Frame starts next cycle
          bit_cnt <= SPI_FRAME_BITS;
        end
      end else if (!n_cs) begin
        bit_cnt <= bit_cnt - 5'd1;
        if (last_bit) begin
          n_cs <= 1'b1;
          if (second_frame) begin
            tx_busy   <= 1'b0;
            pair_done <= 1'b1;
          end else begin
            second_frame <= 1'b1;
            cs_tmr       <= N_CS_HIGH_CYCLES;  // Spacing before frame two
          end
        end
      end
    end
  end

  ////////////////////
  // Shift register
  ////////////////////

  // One shift per low cycle, 24 shifts bring frame two to the top
  always_ff @(posedge clk) begin
    if (start)      shreg <= {frame_pair.first, frame_pair.second};
    else if (!n_cs) shreg <= shreg << 1;
  end

  assign mosi = !n_cs && shreg[$high(shreg)];  // Low while idle

endmodule

// File: source/dac_ctrl_top.sv
module dac_ctrl_top
  import dac_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  cmd_word_t cmd_buf_word,
  input  logic      cmd_buf_empty,
  input  logic      trigger,
  output logic      cmd_buf_rd_en,
  output logic      waiting_for_trig,
  output logic      ldac,
  output logic      n_cs,
  output logic      mosi,
  output dac_err_t  err
);

  pair_req_t   pair_req;    // Sequencer to calibration
  cal_wr_t     cal_wr;
  frame_pair_t frame_pair;  // Calibration to SPI
  logic        tx_busy;
  logic        pair_done;
  logic        cal_oob;
  logic        dac_val_oob;
  dac_err_t    seq_err;

  dac_cmd_sequencer sequencer0 (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_buf_word     (cmd_buf_word),
    .cmd_buf_empty    (cmd_buf_empty),
    .trigger          (trigger),
    .tx_busy          (tx_busy),
    .pair_done        (pair_done),
    .cal_oob          (cal_oob),
    .dac_val_oob      (dac_val_oob),
    .cmd_buf_rd_en    (cmd_buf_rd_en),
    .pair_req         (pair_req),
    .cal_wr           (cal_wr),
    .waiting_for_trig (waiting_for_trig),
    .ldac             (ldac),
    .seq_err          (seq_err)
  );

  dac_cal_stage cal_stage0 (
    .clk         (clk),
    .resetn      (resetn),
    .pair_req    (pair_req),
    .cal_wr      (cal_wr),
    .frame_pair  (frame_pair),
    .cal_oob     (cal_oob),
    .dac_val_oob (dac_val_oob)
  );

  dac_spi_tx spi_tx0 (
    .clk        (clk),
    .resetn     (resetn),
    .frame_pair (frame_pair),
    .tx_busy    (tx_busy),
    .pair_done  (pair_done),
    .n_cs       (n_cs),
    .mosi       (mosi)
  );

  // Calibration flags come from the calibration stage only
  always_comb begin
    err             = seq_err;
    err.cal_oob     = cal_oob;
    err.dac_val_oob = dac_val_oob;
  end

endmodule

// File: dv/tb_dac_ctrl.sv
module tb_dac_ctrl
  import dac_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD = 10;
  localparam int          NUM_RUNS   = 9;     // Resets over all tests
  localparam int          RUN_CYCLES = 3000;  // Budget per run, longest needs about 1100
  localparam logic [31:0] LFSR_SEED  = 32'h16d8_65f7;

  logic      clk;
  logic      resetn;
  cmd_word_t cmd_buf_word  = '0;
  logic      cmd_buf_empty = 1'b1;
  logic      trigger;
  logic      cmd_buf_rd_en;
  logic      waiting_for_trig;
  logic      ldac;
  logic      n_cs;
  logic      mosi;
  dac_err_t  err;

  cmd_word_t          cmd_mem[$];            // Words loaded by the tests
  int                 rd_ptr     = 0;        // Buffer head
  logic               popped     = 1'b0;
  spi_frame_t         got_frames[$];
  spi_frame_t         exp_frames[$];
  logic [23:0]        rx_shift   = '0;
  int                 rx_bits    = 0;
  int                 ldac_cnt   = 0;
  logic signed [15:0] cal_model [NUM_CHANNELS];
  logic [31:0]        lfsr       = LFSR_SEED;
  int                 n_checks   = 0;
  int                 n_errors   = 0;

  dac_ctrl_top dut0 (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_buf_word     (cmd_buf_word),
    .cmd_buf_empty    (cmd_buf_empty),
    .trigger          (trigger),
    .cmd_buf_rd_en    (cmd_buf_rd_en),
    .waiting_for_trig (waiting_for_trig),
    .ldac             (ldac),
    .n_cs             (n_cs),
    .mosi             (mosi),
    .err              (err)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // Buffer and monitors
  ////////////////////

  always @(posedge clk) popped <= cmd_buf_rd_en && !cmd_buf_empty;  // Pop seen by the DUT

  // FWFT head, next word shows on the cycle after a pop
  always @(negedge clk) begin
    if (!resetn) rd_ptr = 0;
    else if (popped) rd_ptr++;
    cmd_buf_empty = (rd_ptr >= cmd_mem.size());
    cmd_buf_word  = cmd_buf_empty ? '0 : cmd_mem[rd_ptr];
  end

  // SPI frame capture, MSB first while n_cs is low
  always @(posedge clk) begin
    if (!resetn) begin
      rx_bits = 0;
      got_frames.delete();
    end else if (!n_cs) begin
      rx_shift = {rx_shift[22:0], mosi};
      rx_bits++;
      if (rx_bits == int'(SPI_FRAME_BITS)) begin
        got_frames.push_back(spi_frame_t'(rx_shift));
        rx_bits = 0;
      end
    end
  end

  always @(posedge clk) begin
    if (!resetn)   ldac_cnt = 0;
    else if (ldac) ldac_cnt++;   // One count per pulse cycle
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Galois LFSR, one step per bit
  function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'hB4BC_D35C;
    return b;
  endfunction

  function automatic logic [15:0] rand_code();
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < 15; i++) v = {v[14:0], lfsr_bit()};
    return v + 16'h2000;  // Keeps room for calibration on both sides
  endfunction

  function automatic cmd_word_t make_cmd(input cmd_op_e op, input logic trig, input logic cont,
                                         input logic ld, input logic [24:0] count);
    cmd_word_t w;
    w       = '0;
    w.op    = op;
    w.trig  = trig;
    w.cont  = cont;
    w.ldac  = ld;
    w.count = count;
    return w;
  endfunction

  // Offset code plus calibration, midscale cancels out
  function automatic spi_frame_t expected_frame(input logic [2:0] ch, input logic [15:0] code);
    spi_frame_t f;
    f.opcode = SPI_OP_REG_WRITE;
    f.rsvd   = 1'b0;
    f.ch     = ch;
    f.code   = code + cal_model[ch];
    return f;
  endfunction

  task automatic push_set_cal(input logic [2:0] ch, input logic signed [15:0] value);
    cmd_mem.push_back(make_cmd(CMD_SET_CAL, 1'b0, 1'b0, 1'b0, {6'd0, ch, value}));
    if (value <= ABS_CAL_MAX && value >= -ABS_CAL_MAX) cal_model[ch] = value;  // Else dropped
  endtask

  // DAC_WR with ldac, four pair words, expected frames in send order
  task automatic push_dac_wr(input logic [24:0] delay, input logic [15:0] codes [NUM_CHANNELS]);
    dac_pair_t p;
    cmd_mem.push_back(make_cmd(CMD_DAC_WR, 1'b0, 1'b0, 1'b1, delay));
    for (int i = 0; i < NUM_CHANNELS; i += 2) begin
      p.even = codes[i];
      p.odd  = codes[i + 1];
      cmd_mem.push_back(cmd_word_t'(p));
      exp_frames.push_back(expected_frame(3'(i), codes[i]));
      exp_frames.push_back(expected_frame(3'(i + 1), codes[i + 1]));
    end
  endtask

  task automatic pulse_trigger(input int n);
    repeat (n) begin
      @(negedge clk);
      trigger = 1'b1;
      @(negedge clk);
      trigger = 1'b0;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  ////////////////////
  // Checks
  ////////////////////

  task automatic report_failure(input string msg);
    n_errors++;
    $display("%s", msg);
  endtask

  task automatic check_frame(input int idx, input spi_frame_t got, input spi_frame_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR mosi frame %0d got %h exp %h", idx, got, exp);
    end
  endtask

  task automatic check_err(input dac_err_t got, input dac_err_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR err got %h exp %h", got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_frames();
    check_count("frame count", got_frames.size(), exp_frames.size());
    for (int i = 0; i < exp_frames.size() && i < got_frames.size(); i++) begin
      check_frame(i, got_frames[i], exp_frames[i]);
    end
  endtask

  task automatic wait_ldac(input int n, input int max_cycles);
    int c;
    c = 0;
    while (ldac_cnt < n && c < max_cycles) begin
      @(negedge clk);
      c++;
    end
    if (ldac_cnt < n) report_failure("Timed out waiting for an ldac pulse");
  endtask

  task automatic wait_wft(input logic level, input int max_cycles);
    int c;
    c = 0;
    while (waiting_for_trig !== level && c < max_cycles) begin
      @(negedge clk);
      c++;
    end
    if (waiting_for_trig !== level) report_failure("waiting_for_trig never reached its level");
  endtask

  // Wait for a flag, then let any stray frame or pulse show up
  task automatic expect_error(input dac_err_t exp, input logic no_frames);
    int c;
    c = 0;
    while (err == '0 && c < 200) begin
      @(negedge clk);
      c++;
    end
    if (err == '0) report_failure("Timed out waiting for an error flag");
    idle(300);
    check_err(err, exp);
    check_count("ldac pulses", ldac_cnt, 0);
    check_bit("n_cs", n_cs, 1'b1);
    if (no_frames) check_count("frame count", got_frames.size(), 0);
  endtask

  // Two reset cycles, words are loaded before release
  task automatic reset_dut();
    @(negedge clk);
    resetn  = 1'b0;
    trigger = 1'b0;
    @(posedge clk);
    cmd_mem.delete();
    exp_frames.delete();
    for (int i = 0; i < NUM_CHANNELS; i++) cal_model[i] = '0;
    @(posedge clk);
    check_bit("cmd_buf_rd_en", cmd_buf_rd_en, 1'b0);
    check_bit("ldac", ldac, 1'b0);
    check_bit("waiting_for_trig", waiting_for_trig, 1'b0);
    check_bit("n_cs", n_cs, 1'b1);
    check_bit("mosi", mosi, 1'b0);
    check_err(err, '0);
  endtask

  task automatic release_reset();
    @(negedge clk);
    resetn = 1'b1;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic plain_write();
    logic [15:0] codes [NUM_CHANNELS];
    reset_dut();
    for (int i = 0; i < NUM_CHANNELS; i++) codes[i] = 16'(16'h0800 * (i + 1) + i);
    push_dac_wr(25'd1000, codes);
    release_reset();
    wait_ldac(1, 1500);
    idle(50);            // A second pulse would land here
    check_frames();
    check_count("ldac pulses", ldac_cnt, 1);
    check_err(err, '0);
  endtask

  task automatic calibrated_write();
    logic [15:0] codes [NUM_CHANNELS];
    reset_dut();
    push_set_cal(3'd1, 16'sd300);
    push_set_cal(3'd4, -16'sd1200);
    push_set_cal(3'd6, 16'sd2000);
    for (int i = 0; i < NUM_CHANNELS; i++) codes[i] = rand_code();
    push_dac_wr(25'd1000, codes);
    release_reset();
    wait_ldac(1, 1500);
    idle(50);
    check_frames();
    check_count("ldac pulses", ldac_cnt, 1);
    check_err(err, '0);
  endtask

  task automatic trigger_waits();
    reset_dut();
    cmd_mem.push_back(make_cmd(CMD_NO_OP, 1'b1, 1'b1, 1'b1, 25'd3));
    cmd_mem.push_back(make_cmd(CMD_NO_OP, 1'b1, 1'b0, 1'b1, 25'd5));
    release_reset();
    wait_wft(1'b1, 20);
    pulse_trigger(2);
    check_bit("waiting_for_trig", waiting_for_trig, 1'b1);
    check_count("ldac pulses", ldac_cnt, 0);
    pulse_trigger(1);    // Third one ends the first wait
    wait_ldac(1, 20);
    check_bit("waiting_for_trig", waiting_for_trig, 1'b1);
    pulse_trigger(1);
    idle(3);
    @(posedge clk);
    cmd_mem.push_back(make_cmd(CMD_CANCEL, 1'b0, 1'b0, 1'b0, 25'd0));
    wait_wft(1'b0, 20);
    idle(10);
    check_count("ldac pulses", ldac_cnt, 1);
    check_err(err, '0);
  endtask

  task automatic range_errors();
    logic [15:0] codes [NUM_CHANNELS];
    dac_err_t    e;
    for (int i = 0; i < NUM_CHANNELS; i++) codes[i] = 16'(16'h1000 * (i + 1));
    e         = '0;
    e.cal_oob = 1'b1;
    reset_dut();
    push_set_cal(3'd2, 16'sd5000);
    push_dac_wr(25'd1000, codes);
    release_reset();
    expect_error(e, 1'b1);
    // Rejected code in pair 0
    e             = '0;
    e.dac_val_oob = 1'b1;
    codes[0]      = DAC_INVALID;
    reset_dut();
    push_dac_wr(25'd1000, codes);
    release_reset();
    expect_error(e, 1'b1);
    // Sum past full scale
    codes[0] = 16'd65000;
    reset_dut();
    push_set_cal(3'd0, 16'sd4000);
    push_dac_wr(25'd1000, codes);
    release_reset();
    expect_error(e, 1'b1);
  endtask

  task automatic command_errors();
    logic [15:0] codes [NUM_CHANNELS];
    dac_err_t    e;
    e         = '0;
    e.bad_cmd = 1'b1;
    reset_dut();
    cmd_mem.push_back(cmd_word_t'({3'd4, 29'd0}));
    cmd_mem.push_back(make_cmd(CMD_NO_OP, 1'b0, 1'b0, 1'b0, 25'd5));
    release_reset();
    expect_error(e, 1'b1);
    @(posedge clk);
    check_count("buffer words left", cmd_mem.size() - rd_ptr, 1);
    // Promised command missing
    e                   = '0;
    e.cmd_buf_underflow = 1'b1;
    reset_dut();
    cmd_mem.push_back(make_cmd(CMD_NO_OP, 1'b0, 1'b1, 1'b1, 25'd20));
    release_reset();
    expect_error(e, 1'b1);
    // Delay shorter than four pairs
    e                 = '0;
    e.delay_too_short = 1'b1;
    for (int i = 0; i < NUM_CHANNELS; i++) codes[i] = rand_code();
    reset_dut();
    push_dac_wr(25'd10, codes);
    release_reset();
    expect_error(e, 1'b0);  // Pair 0 may already be on the wire
  endtask

  ////////////////////
  // Run control
  ////////////////////

  initial begin
    #(NUM_RUNS * RUN_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, a test stopped making progress");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    resetn  = 1'b0;
    trigger = 1'b0;
    plain_write();
    calibrated_write();
    trigger_waits();
    range_errors();
    command_errors();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
source/dac_pkg.sv
source/dac_cmd_sequencer.sv
source/dac_cal_stage.sv
source/dac_spi_tx.sv
source/dac_ctrl_top.sv
dv/tb_dac_ctrl.sv

// File: Makefile
# Verilator build and run for the DAC controller testbench

VERILATOR ?= verilator
TOP       ?= tb_dac_ctrl
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)

check: run
	@if grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "TEST PASSED" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
